//--- mem_pkg.sv
// pipeline side definitions
package mem_pkg;

  // data and address width
  localparam int XLEN   = 64;
  localparam int STRB_W = XLEN / 8;

  // access opcodes with loads before stores
  typedef enum logic [3:0] {
    LB,
    LH,
    LW,
    LD,
    LBU,
    LHU,
    LWU,
    SB,
    SH,
    SW,
    SD
  } mem_op_e;

  // memory stage FSM
  typedef enum logic [1:0] {
    IDLE,  // waiting for a request
    REQ,   // request valid on the bus
    RESP   // waiting for the response
  } lsu_state_e;

endpackage

//--- bus_pkg.sv
// bus and RAM slave definitions
package bus_pkg;

  // doubleword RAM geometry
  localparam int RAM_DEPTH = 512;
  localparam int RAM_AW    = 9;

  // cycles between request accept and response valid
  localparam int RAM_WAIT  = 3;
  localparam int WAIT_W    = $clog2(RAM_WAIT + 1);
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(RAM_WAIT - 1);

  // slave FSM
  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_RESP
  } slave_state_e;

endpackage

//--- lsu_mem_stage.sv
// load/store memory access stage
`timescale 1ns/1ps

module lsu_mem_stage (
  input  logic                        clk,
  input  logic                        arst_n_i,
  // pipeline side
  input  logic                        req_valid_i,
  input  mem_pkg::mem_op_e            op_i,
  input  logic [mem_pkg::XLEN-1:0]    addr_i,
  input  logic [mem_pkg::XLEN-1:0]    wdata_i,
  output logic                        busy_o,
  output logic                        done_o,
  output logic                        misalign_o,
  output logic [mem_pkg::XLEN-1:0]    rdata_o,
  // write request
  output logic                        wr_valid_o,
  input  logic                        wr_ready_i,
  output logic [mem_pkg::XLEN-1:0]    wr_addr_o,
  output logic [mem_pkg::XLEN-1:0]    wr_data_o,
  output logic [mem_pkg::STRB_W-1:0]  wr_strb_o,
  // write response
  input  logic                        wb_valid_i,
  output logic                        wb_ready_o,
  // read request
  output logic                        rd_valid_o,
  input  logic                        rd_ready_i,
  output logic [mem_pkg::XLEN-1:0]    rd_addr_o,
  // read data
  input  logic                        rdata_valid_i,
  output logic                        rdata_ready_o,
  input  logic [mem_pkg::XLEN-1:0]    rdata_i
);

  mem_pkg::lsu_state_e          state_q;
  mem_pkg::mem_op_e             op_q;
  logic                         done_q;
  logic                         misalign_q;
  logic [mem_pkg::XLEN-1:0]     rdata_q;
  logic [2:0]                   off_q;
  logic [mem_pkg::XLEN-1:0]     addr_q;
  logic [mem_pkg::XLEN-1:0]     wdata_q;
  logic [mem_pkg::STRB_W-1:0]   strb_q;

  logic [mem_pkg::STRB_W-1:0]   size_mask;
  logic [2:0]                   align_mask;
  logic                         misaligned;
  logic                         accept;
  logic                         is_store_q;
  logic                         req_fire;
  logic                         resp_fire;
  logic [mem_pkg::XLEN-1:0]     ld_shift;
  logic [mem_pkg::XLEN-1:0]     ld_ext;

  // byte mask of the access size at offset zero
  always_comb begin
    case (op_i)
      mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: size_mask = 8'h01;
      mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: size_mask = 8'h03;
      mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: size_mask = 8'h0f;
      default:                                size_mask = 8'hff;
    endcase
  end

  // size minus one taken from the mask
  assign align_mask = {size_mask[7], size_mask[3], size_mask[1]};
  assign misaligned = |(addr_i[2:0] & align_mask);
  assign accept     = (state_q == mem_pkg::IDLE) && req_valid_i && !misaligned;

  assign is_store_q = op_q inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW, mem_pkg::SD};

  assign req_fire  = (wr_valid_o && wr_ready_i) || (rd_valid_o && rd_ready_i);
  assign resp_fire = (wb_valid_i && wb_ready_o) || (rdata_valid_i && rdata_ready_o);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= mem_pkg::IDLE;
      op_q       <= mem_pkg::LB;
      done_q     <= 1'b0;
      misalign_q <= 1'b0;
      rdata_q    <= '0;
    end else begin
      done_q     <= 1'b0;  // single cycle pulses
      misalign_q <= 1'b0;
      case (state_q)
        mem_pkg::IDLE: begin
          if (req_valid_i && misaligned) begin
            done_q     <= 1'b1;  // never reaches the bus
            misalign_q <= 1'b1;
          end else if (accept) begin
            op_q    <= op_i;
            state_q <= mem_pkg::REQ;
          end
        end
        mem_pkg::REQ: begin
          if (req_fire) state_q <= mem_pkg::RESP;
        end
        mem_pkg::RESP: begin
          if (resp_fire) begin
            done_q  <= 1'b1;
            state_q <= mem_pkg::IDLE;
            if (!is_store_q) rdata_q <= ld_ext;
          end
        end
        default: state_q <= mem_pkg::IDLE;
      endcase
    end
  end

  // request payload shifted into its lane on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr_i;
      off_q   <= addr_i[2:0];
      wdata_q <= wdata_i << {addr_i[2:0], 3'b000};
      strb_q  <= size_mask << addr_i[2:0];
    end
  end

  // shift load data to lane zero and extend
  assign ld_shift = rdata_i >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      mem_pkg::LB:  ld_ext = {{(mem_pkg::XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
      mem_pkg::LH:  ld_ext = {{(mem_pkg::XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
      mem_pkg::LW:  ld_ext = {{(mem_pkg::XLEN-32){ld_shift[31]}}, ld_shift[31:0]};
      mem_pkg::LBU: ld_ext = {{(mem_pkg::XLEN-8){1'b0}}, ld_shift[7:0]};
      mem_pkg::LHU: ld_ext = {{(mem_pkg::XLEN-16){1'b0}}, ld_shift[15:0]};
      mem_pkg::LWU: ld_ext = {{(mem_pkg::XLEN-32){1'b0}}, ld_shift[31:0]};
      default:      ld_ext = ld_shift;  // LD
    endcase
  end

  assign busy_o     = (state_q != mem_pkg::IDLE);
  assign done_o     = done_q;
  assign misalign_o = misalign_q;
  assign rdata_o    = rdata_q;

  assign wr_valid_o    = (state_q == mem_pkg::REQ) && is_store_q;
  assign wr_addr_o     = addr_q;
  assign wr_data_o     = wdata_q;
  assign wr_strb_o     = strb_q;
  assign wb_ready_o    = (state_q == mem_pkg::RESP) && is_store_q;

  assign rd_valid_o    = (state_q == mem_pkg::REQ) && !is_store_q;
  assign rd_addr_o     = addr_q;
  assign rdata_ready_o = (state_q == mem_pkg::RESP) && !is_store_q;

endmodule

//--- bus_ram_slave.sv
// doubleword RAM bus slave
`timescale 1ns/1ps

module bus_ram_slave (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        wr_valid_i,
  output logic                        wr_ready_o,
  input  logic [mem_pkg::XLEN-1:0]    wr_addr_i,
  input  logic [mem_pkg::XLEN-1:0]    wr_data_i,
  input  logic [mem_pkg::STRB_W-1:0]  wr_strb_i,
  output logic                        wb_valid_o,
  input  logic                        wb_ready_i,
  input  logic                        rd_valid_i,
  output logic                        rd_ready_o,
  input  logic [mem_pkg::XLEN-1:0]    rd_addr_i,
  output logic                        rdata_valid_o,
  input  logic                        rdata_ready_i,
  output logic [mem_pkg::XLEN-1:0]    rdata_o
);

  logic [mem_pkg::XLEN-1:0]     mem_q [bus_pkg::RAM_DEPTH];
  bus_pkg::slave_state_e        state_q;
  logic                         is_wr_q;
  logic [bus_pkg::WAIT_W-1:0]   cnt_q;
  logic [mem_pkg::XLEN-1:0]     rdata_q;

  logic                         wr_fire;
  logic                         rd_fire;
  logic                         resp_fire;
  logic [bus_pkg::RAM_AW-1:0]   wr_idx;
  logic [bus_pkg::RAM_AW-1:0]   rd_idx;

  // upper address bits wrap
  assign wr_idx = wr_addr_i[3 +: bus_pkg::RAM_AW];
  assign rd_idx = rd_addr_i[3 +: bus_pkg::RAM_AW];

  // ready only when idle and write wins a tie
  assign wr_ready_o = (state_q == bus_pkg::S_IDLE) && wr_valid_i;
  assign rd_ready_o = (state_q == bus_pkg::S_IDLE) && rd_valid_i && !wr_valid_i;

  assign wr_fire   = wr_valid_i && wr_ready_o;
  assign rd_fire   = rd_valid_i && rd_ready_o;
  assign resp_fire = (wb_valid_o && wb_ready_i) || (rdata_valid_o && rdata_ready_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= bus_pkg::S_IDLE;
      is_wr_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        bus_pkg::S_IDLE: begin
          if (wr_fire || rd_fire) begin
            is_wr_q <= wr_fire;
            cnt_q   <= '0;
            state_q <= bus_pkg::S_WAIT;
          end
        end
        bus_pkg::S_WAIT: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == bus_pkg::WAIT_LAST) state_q <= bus_pkg::S_RESP;
        end
        bus_pkg::S_RESP: begin
          if (resp_fire) state_q <= bus_pkg::S_IDLE;
        end
        default: state_q <= bus_pkg::S_IDLE;
      endcase
    end
  end

  // byte strobed write
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < bus_pkg::RAM_DEPTH; i++) mem_q[i] <= '0;
    end else if (wr_fire) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        if (wr_strb_i[b]) mem_q[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= mem_q[rd_idx];  // held until the response transfers
  end

  assign wb_valid_o    = (state_q == bus_pkg::S_RESP) && is_wr_q;
  assign rdata_valid_o = (state_q == bus_pkg::S_RESP) && !is_wr_q;
  assign rdata_o       = rdata_q;

endmodule

//--- lsu_top.sv
// load/store stage with RAM
`timescale 1ns/1ps

module lsu_top (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  input  mem_pkg::mem_op_e          op_i,
  input  logic [mem_pkg::XLEN-1:0]  addr_i,
  input  logic [mem_pkg::XLEN-1:0]  wdata_i,
  output logic                      busy_o,
  output logic                      done_o,
  output logic                      misalign_o,
  output logic [mem_pkg::XLEN-1:0]  rdata_o
);

  // bus between stage and RAM
  logic                        wr_valid;
  logic                        wr_ready;
  logic [mem_pkg::XLEN-1:0]    wr_addr;
  logic [mem_pkg::XLEN-1:0]    wr_data;
  logic [mem_pkg::STRB_W-1:0]  wr_strb;
  logic                        wb_valid;
  logic                        wb_ready;
  logic                        rd_valid;
  logic                        rd_ready;
  logic [mem_pkg::XLEN-1:0]    rd_addr;
  logic                        rdata_valid;
  logic                        rdata_ready;
  logic [mem_pkg::XLEN-1:0]    rdata;

  lsu_mem_stage stage_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (req_valid_i),
    .op_i          (op_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .misalign_o    (misalign_o),
    .rdata_o       (rdata_o),
    .wr_valid_o    (wr_valid),
    .wr_ready_i    (wr_ready),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .wr_strb_o     (wr_strb),
    .wb_valid_i    (wb_valid),
    .wb_ready_o    (wb_ready),
    .rd_valid_o    (rd_valid),
    .rd_ready_i    (rd_ready),
    .rd_addr_o     (rd_addr),
    .rdata_valid_i (rdata_valid),
    .rdata_ready_o (rdata_ready),
    .rdata_i       (rdata)
  );

  bus_ram_slave ram_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .wr_valid_i    (wr_valid),
    .wr_ready_o    (wr_ready),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .wr_strb_i     (wr_strb),
    .wb_valid_o    (wb_valid),
    .wb_ready_i    (wb_ready),
    .rd_valid_i    (rd_valid),
    .rd_ready_o    (rd_ready),
    .rd_addr_i     (rd_addr),
    .rdata_valid_o (rdata_valid),
    .rdata_ready_i (rdata_ready),
    .rdata_o       (rdata)
  );

endmodule

//--- tb_lsu_top.sv
// load/store stage testbench
`timescale 1ns/1ps

module tb_lsu_top;

  localparam int MAX_ROWS = 64;

  logic                      clk;
  logic                      arst_n_i;
  logic                      req_valid_i;
  mem_pkg::mem_op_e          op_i;
  logic [mem_pkg::XLEN-1:0]  addr_i;
  logic [mem_pkg::XLEN-1:0]  wdata_i;
  logic                      busy_o;
  logic                      done_o;
  logic                      misalign_o;
  logic [mem_pkg::XLEN-1:0]  rdata_o;

  // stimulus table
  string             t_name [MAX_ROWS];
  mem_pkg::mem_op_e  t_op   [MAX_ROWS];
  logic [63:0]       t_addr [MAX_ROWS];
  logic [63:0]       t_data [MAX_ROWS];
  bit                t_hold [MAX_ROWS];
  bit                t_mis  [MAX_ROWS];
  int                n_rows;

  logic [63:0] shadow [64];  // first 64 doublewords of the RAM
  integer      seed;
  int          errors, passes, done_cnt, cycles;
  bit          row_ok;
  logic [63:0] exp_val;

  lsu_top dut_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .op_i        (op_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .misalign_o  (misalign_o),
    .rdata_o     (rdata_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(negedge clk) if (done_o) done_cnt++;

  always @(posedge clk) begin
    cycles++;
    if (cycles > n_rows * (2 * bus_pkg::RAM_WAIT + 8) + 20) begin
      $display("timeout: run went past %0d cycles without finishing", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic int size_bytes(input mem_pkg::mem_op_e op);
    case (op)
      mem_pkg::LB, mem_pkg::LBU, mem_pkg::SB: return 1;
      mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: return 2;
      mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: return 4;
      default:                                return 8;
    endcase
  endfunction

  function automatic bit is_store(input mem_pkg::mem_op_e op);
    return op inside {mem_pkg::SB, mem_pkg::SH, mem_pkg::SW, mem_pkg::SD};
  endfunction

  function automatic bit is_signed_load(input mem_pkg::mem_op_e op);
    return op inside {mem_pkg::LB, mem_pkg::LH, mem_pkg::LW};
  endfunction

  // pick bytes from the lane and extend
  function automatic logic [63:0] load_value(input mem_pkg::mem_op_e op, input logic [63:0] addr);
    logic [63:0] word;
    logic [63:0] v;
    int          off;
    int          nb;
    word = shadow[addr[8:3]];
    off  = addr[2:0];
    nb   = size_bytes(op);
    v    = '0;
    for (int b = 0; b < nb; b++) v[8*b +: 8] = word[8*(off+b) +: 8];
    if (is_signed_load(op) && v[8*nb-1]) begin
      for (int b = nb; b < 8; b++) v[8*b +: 8] = 8'hff;
    end
    return v;
  endfunction

  task automatic apply_store(input mem_pkg::mem_op_e op, input logic [63:0] addr,
                             input logic [63:0] data);
    int off;
    off = addr[2:0];
    for (int b = 0; b < size_bytes(op); b++) shadow[addr[8:3]][8*(off+b) +: 8] = data[8*b +: 8];
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic add_row(input string name, input mem_pkg::mem_op_e op, input logic [63:0] addr,
                         input logic [63:0] data, input bit hold, input bit mis);
    t_name[n_rows] = name;
    t_op[n_rows]   = op;
    t_addr[n_rows] = addr;
    t_data[n_rows] = data;
    t_hold[n_rows] = hold;
    t_mis[n_rows]  = mis;
    n_rows++;
  endtask

  task automatic build_table();
    logic [63:0] neg;
    logic [63:0] pos;
    seed   = 32'h32a97f16;
    n_rows = 0;
    add_row("sd_round_trip", mem_pkg::SD, 64'h08, rand64(), 0, 0);
    add_row("ld_round_trip", mem_pkg::LD, 64'h08, '0, 0, 0);
    // sub-word stores merging into known doublewords
    add_row("sd_base_sb", mem_pkg::SD, 64'h20, rand64(), 0, 0);
    for (int o = 0; o < 8; o++) begin
      add_row($sformatf("sb_off%0d", o), mem_pkg::SB, 64'h20 + o, rand64(), 0, 0);
    end
    add_row("ld_after_sb", mem_pkg::LD, 64'h20, '0, 0, 0);
    add_row("sd_base_sh", mem_pkg::SD, 64'h28, rand64(), 0, 0);
    for (int o = 0; o < 8; o += 2) begin
      add_row($sformatf("sh_off%0d", o), mem_pkg::SH, 64'h28 + o, rand64(), 0, 0);
    end
    add_row("ld_after_sh", mem_pkg::LD, 64'h28, '0, 0, 0);
    add_row("sd_base_sw", mem_pkg::SD, 64'h30, rand64(), 0, 0);
    add_row("sw_off0", mem_pkg::SW, 64'h30, rand64(), 0, 0);
    add_row("sw_off4", mem_pkg::SW, 64'h34, rand64(), 0, 0);
    add_row("ld_after_sw", mem_pkg::LD, 64'h30, '0, 0, 0);
    // every byte negative at 0x40 and positive at 0x48
    neg = rand64() | 64'h8080_8080_8080_8080;
    pos = rand64() & 64'h7f7f_7f7f_7f7f_7f7f;
    add_row("sd_neg", mem_pkg::SD, 64'h40, neg, 0, 0);
    add_row("sd_pos", mem_pkg::SD, 64'h48, pos, 0, 0);
    for (int k = 0; k < 2; k++) begin
      add_row($sformatf("lb_%0d", k),  mem_pkg::LB,  64'h43 + 8*k, '0, 0, 0);
      add_row($sformatf("lbu_%0d", k), mem_pkg::LBU, 64'h43 + 8*k, '0, 0, 0);
      add_row($sformatf("lh_%0d", k),  mem_pkg::LH,  64'h42 + 8*k, '0, 0, 0);
      add_row($sformatf("lhu_%0d", k), mem_pkg::LHU, 64'h46 + 8*k, '0, 0, 0);
      add_row($sformatf("lw_%0d", k),  mem_pkg::LW,  64'h44 + 8*k, '0, 0, 0);
      add_row($sformatf("lwu_%0d", k), mem_pkg::LWU, 64'h44 + 8*k, '0, 0, 0);
    end
    add_row("mis_lh", mem_pkg::LH, 64'h21, '0, 0, 1);
    add_row("mis_lhu", mem_pkg::LHU, 64'h23, '0, 0, 1);
    add_row("mis_lw", mem_pkg::LW, 64'h22, '0, 0, 1);
    add_row("mis_lwu", mem_pkg::LWU, 64'h29, '0, 0, 1);
    add_row("mis_ld", mem_pkg::LD, 64'h24, '0, 0, 1);
    add_row("mis_sh", mem_pkg::SH, 64'h23, rand64(), 0, 1);
    add_row("mis_sw", mem_pkg::SW, 64'h26, rand64(), 0, 1);
    add_row("mis_sd", mem_pkg::SD, 64'h2c, rand64(), 0, 1);
    add_row("ld_no_change_20", mem_pkg::LD, 64'h20, '0, 0, 0);
    add_row("ld_no_change_28", mem_pkg::LD, 64'h28, '0, 0, 0);
    // req_valid_i held through busy
    add_row("sw_hold", mem_pkg::SW, 64'h54, rand64(), 1, 0);
    add_row("ld_after_sw_hold", mem_pkg::LD, 64'h50, '0, 0, 0);
    add_row("sb_hold", mem_pkg::SB, 64'h57, rand64(), 1, 0);
    add_row("ld_after_sb_hold", mem_pkg::LD, 64'h50, '0, 1, 0);
    add_row("lw_hold", mem_pkg::LW, 64'h54, '0, 1, 0);
  endtask

  task automatic check_row(input int r);
    row_ok = 1'b1;
    assert (misalign_o == t_mis[r]) else begin
      $display("[FAIL] %s misalign_o expected %0b actual %0b", t_name[r], t_mis[r], misalign_o);
      row_ok = 1'b0;
    end
    assert (!busy_o) else begin
      $display("[FAIL] %s busy_o expected 0 actual %0b", t_name[r], busy_o);
      row_ok = 1'b0;
    end
    if (!t_mis[r]) begin
      if (is_store(t_op[r])) begin
        apply_store(t_op[r], t_addr[r], t_data[r]);
      end else begin
        exp_val = load_value(t_op[r], t_addr[r]);
        assert (rdata_o == exp_val) else begin
          $display("[FAIL] %s rdata_o expected %h actual %h", t_name[r], exp_val, rdata_o);
          row_ok = 1'b0;
        end
      end
    end
    if (row_ok) begin
      passes++;
      $display("[PASS] %s", t_name[r]);
    end else begin
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    @(negedge clk);
    req_valid_i = 1'b1;
    op_i        = t_op[r];
    addr_i      = t_addr[r];
    wdata_i     = t_data[r];
    do begin
      @(negedge clk);
      if (!t_hold[r]) req_valid_i = 1'b0;  // single cycle pulse
    end while (!done_o);
    req_valid_i = 1'b0;
    check_row(r);
  endtask

  initial begin
    arst_n_i    = 1'b0;
    req_valid_i = 1'b0;
    op_i        = mem_pkg::LB;
    addr_i      = '0;
    wdata_i     = '0;
    errors      = 0;
    passes      = 0;
    done_cnt    = 0;
    cycles      = 0;
    for (int i = 0; i < 64; i++) shadow[i] = '0;
    build_table();
    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;
    for (int r = 0; r < n_rows; r++) run_row(r);
    @(negedge clk);
    // one done pulse per row, so no access was repeated
    assert (done_cnt == n_rows && !busy_o) else begin
      $display("done_o pulsed %0d times for %0d accesses, or busy_o stayed high",
               done_cnt, n_rows);
      errors++;
    end
    $display("tests passed %0d, failed %0d", passes, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
mem_pkg.sv
bus_pkg.sv
lsu_mem_stage.sv
bus_ram_slave.sv
lsu_top.sv
tb_lsu_top.sv

//--- Bender.yml
package:
  name: lsu_top

sources:
  - mem_pkg.sv
  - bus_pkg.sv
  - lsu_mem_stage.sv
  - bus_ram_slave.sv
  - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu_top.sv
